// ==== la_ctrl_encode.sv ====
`timescale 1ns/10ps

module la_ctrl_encode import la_decode_pkg::*; (
  input  inst_t       i_inst,
  input  inst_flags_t i_flags,
  input  logic        i_illegal,
  output logic        o_reg_write,
  output logic        o_mem_write,
  output logic        o_mem_read,
  output logic        o_alu_src1_pc,
  output logic        o_alu_src2_imm,
  output alu_op_t     o_alu_op,
  output npc_op_t     o_npc_op,
  output dm_type_t    o_dm_type,
  output wd_sel_t     o_wd_sel,
  output reg_idx_t    o_rd,
  output reg_idx_t    o_rs1,
  output reg_idx_t    o_rs2
);

  logic is_load;
  logic is_store;
  logic is_cbr;   // conditional branches
  logic is_imm;   // alu ops with immediate operand
  logic is_link;  // jirl / bl write pc + 4

  ////////////////////
  // instruction classes

  assign is_load  = i_flags[F_LD_B] | i_flags[F_LD_H] | i_flags[F_LD_W]
                  | i_flags[F_LD_BU] | i_flags[F_LD_HU];
  assign is_store = i_flags[F_ST_B] | i_flags[F_ST_H] | i_flags[F_ST_W];
  assign is_cbr   = i_flags[F_BEQ] | i_flags[F_BNE] | i_flags[F_BLT] | i_flags[F_BGE]
                  | i_flags[F_BLTU] | i_flags[F_BGEU];
  assign is_imm   = i_flags[F_SLLI_W] | i_flags[F_SRLI_W] | i_flags[F_SRAI_W]
                  | i_flags[F_ADDI_W] | i_flags[F_SLTI] | i_flags[F_SLTUI]
                  | i_flags[F_ANDI] | i_flags[F_ORI] | i_flags[F_XORI];
  assign is_link  = i_flags[F_JIRL] | i_flags[F_BL];

  ////////////////////
  // alu op, flags are at most one-hot

  always_comb begin
    o_alu_op = ALU_NOP;  // also the illegal case
    if (i_flags[F_ADD_W] | i_flags[F_ADDI_W] | is_load | is_store | i_flags[F_B]
        | is_link | i_flags[F_PCADDU12I])        o_alu_op = ALU_ADD;
    else if (i_flags[F_LU12I_W])                 o_alu_op = ALU_LUI;
    else if (i_flags[F_SUB_W])                   o_alu_op = ALU_SUB;
    else if (i_flags[F_SLT] | i_flags[F_SLTI])   o_alu_op = ALU_SLT;
    else if (i_flags[F_SLTU] | i_flags[F_SLTUI]) o_alu_op = ALU_SLTU;
    else if (i_flags[F_NOR])                     o_alu_op = ALU_NOR;
    else if (i_flags[F_AND] | i_flags[F_ANDI])   o_alu_op = ALU_AND;
    else if (i_flags[F_OR] | i_flags[F_ORI])     o_alu_op = ALU_OR;
    else if (i_flags[F_XOR] | i_flags[F_XORI])   o_alu_op = ALU_XOR;
    else if (i_flags[F_SLL_W] | i_flags[F_SLLI_W]) o_alu_op = ALU_SLL;
    else if (i_flags[F_SRL_W] | i_flags[F_SRLI_W]) o_alu_op = ALU_SRL;
    else if (i_flags[F_SRA_W] | i_flags[F_SRAI_W]) o_alu_op = ALU_SRA;
    else if (i_flags[F_BEQ])                     o_alu_op = ALU_BEQ;
    else if (i_flags[F_BNE])                     o_alu_op = ALU_BNE;
    else if (i_flags[F_BLT])                     o_alu_op = ALU_BLT;
    else if (i_flags[F_BGE])                     o_alu_op = ALU_BGE;
    else if (i_flags[F_BLTU])                    o_alu_op = ALU_BLTU;
    else if (i_flags[F_BGEU])                    o_alu_op = ALU_BGEU;
    else if (i_flags[F_MUL_W])                   o_alu_op = ALU_MULW;
    else if (i_flags[F_MULH_W])                  o_alu_op = ALU_MULHW;
    else if (i_flags[F_MULH_WU])                 o_alu_op = ALU_MULHWU;
    else if (i_flags[F_DIV_W])                   o_alu_op = ALU_DIVW;
    else if (i_flags[F_MOD_W])                   o_alu_op = ALU_MODW;
    else if (i_flags[F_DIV_WU])                  o_alu_op = ALU_DIVWU;
    else if (i_flags[F_MOD_WU])                  o_alu_op = ALU_MODWU;
  end

  ////////////////////
  // next pc, operands, write-back

  assign o_npc_op = is_cbr                       ? NPC_BRANCH :
                    (i_flags[F_B] | i_flags[F_BL]) ? NPC_JUMP :
                    i_flags[F_JIRL]              ? NPC_JIRL   : NPC_PLUS4;

  assign o_alu_src1_pc  = is_link | i_flags[F_PCADDU12I];
  assign o_alu_src2_imm = is_imm | is_load | is_store | is_link
                        | i_flags[F_LU12I_W] | i_flags[F_PCADDU12I];

  assign o_wd_sel = is_load ? WD_MEM :
                    is_link ? WD_PC  : WD_ALU;

  assign o_dm_type = (i_flags[F_LD_H] | i_flags[F_ST_H]) ? DM_HALF   :
                     i_flags[F_LD_HU]                    ? DM_HALF_U :
                     (i_flags[F_LD_B] | i_flags[F_ST_B]) ? DM_BYTE   :
                     i_flags[F_LD_BU]                    ? DM_BYTE_U : DM_WORD;

  assign o_mem_read  = is_load;
  assign o_mem_write = is_store;
  // b and conditional branches write nothing, bl/jirl do
  assign o_reg_write = ~i_illegal & ~is_store & ~is_cbr & ~i_flags[F_B];

  ////////////////////
  // register indices

  assign o_rd  = i_flags[F_BL] ? LINK_REG : i_inst[RD_LSB +: 5];
  assign o_rs1 = i_inst[RJ_LSB +: 5];
  assign o_rs2 = (is_store | is_cbr) ? i_inst[RD_LSB +: 5]  // rd is the source here
                                     : i_inst[RK_LSB +: 5];

endmodule

// ==== la_decode_pkg.sv ====
package la_decode_pkg;

  ////////////////////
  // base types

  typedef logic [31:0] inst_t;     // raw instruction word
  typedef logic [31:0] word_t;     // data or immediate
  typedef logic [4:0]  reg_idx_t;  // gpr index
  typedef logic [4:0]  alu_op_t;
  typedef logic [4:0]  npc_op_t;
  typedef logic [2:0]  dm_type_t;
  typedef logic [1:0]  wd_sel_t;

  localparam int NUM_INST = 46;
  typedef logic [NUM_INST-1:0] inst_flags_t;  // one bit per instruction

  // flag bit positions, grouped by class
  localparam int
    F_ADD_W     = 0,  F_SUB_W   = 1,  F_SLT     = 2,  F_SLTU    = 3,
    F_NOR       = 4,  F_AND     = 5,  F_OR      = 6,  F_XOR     = 7,
    F_SLL_W     = 8,  F_SRL_W   = 9,  F_SRA_W   = 10, F_MUL_W   = 11,
    F_MULH_W    = 12, F_MULH_WU = 13, F_DIV_W   = 14, F_MOD_W   = 15,
    F_DIV_WU    = 16, F_MOD_WU  = 17, F_SLLI_W  = 18, F_SRLI_W  = 19,
    F_SRAI_W    = 20, F_ADDI_W  = 21, F_SLTI    = 22, F_SLTUI   = 23,
    F_ANDI      = 24, F_ORI     = 25, F_XORI    = 26, F_LU12I_W = 27,
    F_PCADDU12I = 28, F_LD_B    = 29, F_LD_H    = 30, F_LD_W    = 31,
    F_LD_BU     = 32, F_LD_HU   = 33, F_ST_B    = 34, F_ST_H    = 35,
    F_ST_W      = 36, F_JIRL    = 37, F_B       = 38, F_BL      = 39,
    F_BEQ       = 40, F_BNE     = 41, F_BLT     = 42, F_BGE     = 43,
    F_BLTU      = 44, F_BGEU    = 45;

  ////////////////////
  // control codes

  localparam alu_op_t
    ALU_NOP   = 5'd0,  ALU_LUI    = 5'd1,  ALU_ADD    = 5'd3,  ALU_SUB   = 5'd4,
    ALU_BNE   = 5'd5,  ALU_BLT    = 5'd6,  ALU_BGE    = 5'd7,  ALU_BLTU  = 5'd8,
    ALU_BGEU  = 5'd9,  ALU_SLT    = 5'd10, ALU_SLTU   = 5'd11, ALU_XOR   = 5'd12,
    ALU_OR    = 5'd13, ALU_AND    = 5'd14, ALU_SLL    = 5'd15, ALU_SRL   = 5'd16,
    ALU_SRA   = 5'd17, ALU_NOR    = 5'd18, ALU_BEQ    = 5'd19, ALU_MULW  = 5'd20,
    ALU_MULHW = 5'd21, ALU_MULHWU = 5'd22, ALU_DIVW   = 5'd23, ALU_MODW  = 5'd24,
    ALU_DIVWU = 5'd25, ALU_MODWU  = 5'd26;

  localparam npc_op_t NPC_PLUS4  = 5'd0;
  localparam npc_op_t NPC_BRANCH = 5'd1;
  localparam npc_op_t NPC_JUMP   = 5'd6;   // b and bl
  localparam npc_op_t NPC_JIRL   = 5'd24;

  localparam dm_type_t DM_WORD   = 3'd0;
  localparam dm_type_t DM_HALF   = 3'd1;
  localparam dm_type_t DM_HALF_U = 3'd2;
  localparam dm_type_t DM_BYTE   = 3'd3;
  localparam dm_type_t DM_BYTE_U = 3'd4;

  localparam wd_sel_t WD_ALU = 2'd0;
  localparam wd_sel_t WD_MEM = 2'd1;
  localparam wd_sel_t WD_PC  = 2'd2;

  localparam reg_idx_t LINK_REG  = 5'd1;   // r1 = ra
  localparam word_t    IMM_PLUS4 = 32'd4;

  ////////////////////
  // instruction fields

  localparam int OP6_LSB = 26;
  localparam int OP4_LSB = 22;
  localparam int OP2_LSB = 20;
  localparam int OP5_LSB = 15;
  localparam int RK_LSB  = 10;
  localparam int RJ_LSB  = 5;
  localparam int RD_LSB  = 0;
  localparam int IMM_LSB = 10;  // start of ui5/si12/si16 fields
  localparam int I20_LSB = 5;

  // major opcode, bits 31..26
  localparam logic [5:0]
    OP6_ALU  = 6'h00, OP6_LU12I = 6'h05, OP6_PCADDU = 6'h07, OP6_MEM  = 6'h0a,
    OP6_JIRL = 6'h13, OP6_B     = 6'h14, OP6_BL     = 6'h15, OP6_BEQ  = 6'h16,
    OP6_BNE  = 6'h17, OP6_BLT   = 6'h18, OP6_BGE    = 6'h19, OP6_BLTU = 6'h1a,
    OP6_BGEU = 6'h1b;

  // bits 25..22, alu group then memory group
  localparam logic [3:0]
    OP4_REG  = 4'h0, OP4_SHIFT = 4'h1, OP4_SLTI = 4'h8, OP4_SLTUI = 4'h9,
    OP4_ADDI = 4'ha, OP4_ANDI  = 4'hd, OP4_ORI  = 4'he, OP4_XORI  = 4'hf,
    OP4_LD_B = 4'h0, OP4_LD_H  = 4'h1, OP4_LD_W = 4'h2, OP4_ST_B  = 4'h4,
    OP4_ST_H = 4'h5, OP4_ST_W  = 4'h6, OP4_LD_BU = 4'h8, OP4_LD_HU = 4'h9;

  localparam logic [1:0] OP2_SHIFT = 2'h0, OP2_ALU = 2'h1, OP2_MULDIV = 2'h2;

  // bits 19..15
  localparam logic [4:0]
    OP5_ADD  = 5'h00, OP5_SUB  = 5'h02, OP5_SLT   = 5'h04, OP5_SLTU  = 5'h05,
    OP5_NOR  = 5'h08, OP5_AND  = 5'h09, OP5_OR    = 5'h0a, OP5_XOR   = 5'h0b,
    OP5_SLL  = 5'h0e, OP5_SRL  = 5'h0f, OP5_SRA   = 5'h10, OP5_MUL   = 5'h18,
    OP5_MULH = 5'h19, OP5_MULHU = 5'h1a, OP5_DIV  = 5'h00, OP5_MOD   = 5'h01,
    OP5_DIVU = 5'h02, OP5_MODU = 5'h03, OP5_SLLI  = 5'h01, OP5_SRLI  = 5'h09,
    OP5_SRAI = 5'h11;

endpackage

// ==== la_decode_stage.sv ====
`timescale 1ns/10ps

module la_decode_stage import la_decode_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  inst_t    i_inst,
  output logic     o_valid,
  output logic     o_reg_write,
  output logic     o_mem_write,
  output logic     o_mem_read,
  output logic     o_alu_src1_pc,
  output logic     o_alu_src2_imm,
  output alu_op_t  o_alu_op,
  output npc_op_t  o_npc_op,
  output dm_type_t o_dm_type,
  output wd_sel_t  o_wd_sel,
  output reg_idx_t o_rd,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output word_t    o_imm_alu,
  output word_t    o_imm_pc,
  output logic     o_illegal
);

  inst_flags_t flags;
  logic        illegal;
  logic        reg_write;
  logic        mem_write;
  logic        mem_read;
  logic        alu_src1_pc;
  logic        alu_src2_imm;
  alu_op_t     alu_op;
  npc_op_t     npc_op;
  dm_type_t    dm_type;
  wd_sel_t     wd_sel;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       imm_alu;
  word_t       imm_pc;

  la_inst_match u_match (
    .i_inst    (i_inst),
    .o_flags   (flags),
    .o_illegal (illegal)
  );

  la_imm_gen u_imm (
    .i_inst    (i_inst),
    .i_flags   (flags),
    .o_imm_alu (imm_alu),
    .o_imm_pc  (imm_pc)
  );

  la_ctrl_encode u_ctrl (
    .i_inst         (i_inst),
    .i_flags        (flags),
    .i_illegal      (illegal),
    .o_reg_write    (reg_write),
    .o_mem_write    (mem_write),
    .o_mem_read     (mem_read),
    .o_alu_src1_pc  (alu_src1_pc),
    .o_alu_src2_imm (alu_src2_imm),
    .o_alu_op       (alu_op),
    .o_npc_op       (npc_op),
    .o_dm_type      (dm_type),
    .o_wd_sel       (wd_sel),
    .o_rd           (rd),
    .o_rs1          (rs1),
    .o_rs2          (rs2)
  );

  ////////////////////
  // output register

  // valid and enables drop on any bubble
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid     <= 1'b0;
      o_reg_write <= 1'b0;
      o_mem_write <= 1'b0;
      o_mem_read  <= 1'b0;
    end else begin
      o_valid     <= i_valid;
      o_reg_write <= i_valid & reg_write;
      o_mem_write <= i_valid & mem_write;
      o_mem_read  <= i_valid & mem_read;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin  // payload holds across bubbles
      o_alu_src1_pc  <= alu_src1_pc;
      o_alu_src2_imm <= alu_src2_imm;
      o_alu_op       <= alu_op;
      o_npc_op       <= npc_op;
      o_dm_type      <= dm_type;
      o_wd_sel       <= wd_sel;
      o_rd           <= rd;
      o_rs1          <= rs1;
      o_rs2          <= rs2;
      o_imm_alu      <= imm_alu;
      o_imm_pc       <= imm_pc;
      o_illegal      <= illegal;
    end
  end

endmodule

// ==== la_imm_gen.sv ====
`timescale 1ns/10ps

module la_imm_gen import la_decode_pkg::*; (
  input  inst_t       i_inst,
  input  inst_flags_t i_flags,
  output word_t       o_imm_alu,
  output word_t       o_imm_pc
);

  logic [4:0]  i5;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;
  word_t       imm_si16;
  word_t       imm_si26;

  logic need_ui5;
  logic need_ui12;
  logic need_si16;
  logic need_si20;
  logic need_si26;
  logic src2_is_4;  // link value pc + 4

  assign i5  = i_inst[IMM_LSB +: 5];
  assign i12 = i_inst[IMM_LSB +: 12];
  assign i16 = i_inst[IMM_LSB +: 16];
  assign i20 = i_inst[I20_LSB +: 20];
  assign i26 = {i_inst[RD_LSB +: 10], i16};  // offs[25:16] lives in the low bits

  assign imm_si16 = {{14{i16[15]}}, i16, 2'b00};
  assign imm_si26 = {{4{i26[25]}}, i26, 2'b00};

  assign need_ui5  = i_flags[F_SLLI_W] | i_flags[F_SRLI_W] | i_flags[F_SRAI_W];
  assign need_ui12 = i_flags[F_ANDI] | i_flags[F_ORI] | i_flags[F_XORI];
  assign need_si16 = i_flags[F_JIRL] | i_flags[F_BEQ] | i_flags[F_BNE] | i_flags[F_BLT]
                   | i_flags[F_BGE] | i_flags[F_BLTU] | i_flags[F_BGEU];
  assign need_si20 = i_flags[F_LU12I_W] | i_flags[F_PCADDU12I];
  assign need_si26 = i_flags[F_B] | i_flags[F_BL];
  assign src2_is_4 = i_flags[F_JIRL] | i_flags[F_BL];

  always_comb begin
    if (src2_is_4)      o_imm_alu = IMM_PLUS4;
    else if (need_si20) o_imm_alu = {i20, 12'b0};
    else if (need_si16) o_imm_alu = imm_si16;
    else if (need_si26) o_imm_alu = imm_si26;
    else if (need_ui5)  o_imm_alu = {27'b0, i5};
    else if (need_ui12) o_imm_alu = {20'b0, i12};
    else                o_imm_alu = {{20{i12[11]}}, i12};  // si12 default
  end

  assign o_imm_pc = need_si26 ? imm_si26 :
                    need_si16 ? imm_si16 : '0;

endmodule

// ==== la_inst_match.sv ====
`timescale 1ns/10ps

module la_inst_match import la_decode_pkg::*; (
  input  inst_t       i_inst,
  output inst_flags_t o_flags,
  output logic        o_illegal
);

  logic [5:0]  op6;
  logic [3:0]  op4;
  logic [1:0]  op2;
  logic [4:0]  op5;

  logic [63:0] op6_d;
  logic [15:0] op4_d;
  logic [3:0]  op2_d;
  logic [31:0] op5_d;

  logic alu_grp;   // op6 == 0
  logic r3_grp;    // three-register alu ops
  logic r3m_grp;   // mul/div/mod
  logic shi_grp;   // shift by immediate
  logic mem_grp;

  ////////////////////
  // field split and one-hot predecode

  assign op6 = i_inst[OP6_LSB +: 6];
  assign op4 = i_inst[OP4_LSB +: 4];
  assign op2 = i_inst[OP2_LSB +: 2];
  assign op5 = i_inst[OP5_LSB +: 5];

  assign op6_d = 64'd1 << op6;
  assign op4_d = 16'd1 << op4;
  assign op2_d = 4'd1 << op2;
  assign op5_d = 32'd1 << op5;

  assign alu_grp = op6_d[OP6_ALU];
  assign r3_grp  = alu_grp & op4_d[OP4_REG] & op2_d[OP2_ALU];
  assign r3m_grp = alu_grp & op4_d[OP4_REG] & op2_d[OP2_MULDIV];
  assign shi_grp = alu_grp & op4_d[OP4_SHIFT] & op2_d[OP2_SHIFT];
  assign mem_grp = op6_d[OP6_MEM];

  ////////////////////
  // per-instruction match

  assign o_flags[F_ADD_W]   = r3_grp & op5_d[OP5_ADD];
  assign o_flags[F_SUB_W]   = r3_grp & op5_d[OP5_SUB];
  assign o_flags[F_SLT]     = r3_grp & op5_d[OP5_SLT];
  assign o_flags[F_SLTU]    = r3_grp & op5_d[OP5_SLTU];
  assign o_flags[F_NOR]     = r3_grp & op5_d[OP5_NOR];
  assign o_flags[F_AND]     = r3_grp & op5_d[OP5_AND];
  assign o_flags[F_OR]      = r3_grp & op5_d[OP5_OR];
  assign o_flags[F_XOR]     = r3_grp & op5_d[OP5_XOR];
  assign o_flags[F_SLL_W]   = r3_grp & op5_d[OP5_SLL];
  assign o_flags[F_SRL_W]   = r3_grp & op5_d[OP5_SRL];
  assign o_flags[F_SRA_W]   = r3_grp & op5_d[OP5_SRA];
  assign o_flags[F_MUL_W]   = r3_grp & op5_d[OP5_MUL];
  assign o_flags[F_MULH_W]  = r3_grp & op5_d[OP5_MULH];
  assign o_flags[F_MULH_WU] = r3_grp & op5_d[OP5_MULHU];

  // div/mod sit in the op2 == 2 page
  assign o_flags[F_DIV_W]  = r3m_grp & op5_d[OP5_DIV];
  assign o_flags[F_MOD_W]  = r3m_grp & op5_d[OP5_MOD];
  assign o_flags[F_DIV_WU] = r3m_grp & op5_d[OP5_DIVU];
  assign o_flags[F_MOD_WU] = r3m_grp & op5_d[OP5_MODU];

  assign o_flags[F_SLLI_W] = shi_grp & op5_d[OP5_SLLI];
  assign o_flags[F_SRLI_W] = shi_grp & op5_d[OP5_SRLI];
  assign o_flags[F_SRAI_W] = shi_grp & op5_d[OP5_SRAI];

  // 12-bit immediate forms only look at op4
  assign o_flags[F_ADDI_W] = alu_grp & op4_d[OP4_ADDI];
  assign o_flags[F_SLTI]   = alu_grp & op4_d[OP4_SLTI];
  assign o_flags[F_SLTUI]  = alu_grp & op4_d[OP4_SLTUI];
  assign o_flags[F_ANDI]   = alu_grp & op4_d[OP4_ANDI];
  assign o_flags[F_ORI]    = alu_grp & op4_d[OP4_ORI];
  assign o_flags[F_XORI]   = alu_grp & op4_d[OP4_XORI];

  // op4[3] is inst bit 25, must be clear for the 20-bit forms
  assign o_flags[F_LU12I_W]   = op6_d[OP6_LU12I] & ~op4[3];
  assign o_flags[F_PCADDU12I] = op6_d[OP6_PCADDU] & ~op4[3];

  assign o_flags[F_LD_B]  = mem_grp & op4_d[OP4_LD_B];
  assign o_flags[F_LD_H]  = mem_grp & op4_d[OP4_LD_H];
  assign o_flags[F_LD_W]  = mem_grp & op4_d[OP4_LD_W];
  assign o_flags[F_LD_BU] = mem_grp & op4_d[OP4_LD_BU];
  assign o_flags[F_LD_HU] = mem_grp & op4_d[OP4_LD_HU];
  assign o_flags[F_ST_B]  = mem_grp & op4_d[OP4_ST_B];
  assign o_flags[F_ST_H]  = mem_grp & op4_d[OP4_ST_H];
  assign o_flags[F_ST_W]  = mem_grp & op4_d[OP4_ST_W];

  assign o_flags[F_JIRL] = op6_d[OP6_JIRL];  // control transfer, op6 only
  assign o_flags[F_B]    = op6_d[OP6_B];
  assign o_flags[F_BL]   = op6_d[OP6_BL];
  assign o_flags[F_BEQ]  = op6_d[OP6_BEQ];
  assign o_flags[F_BNE]  = op6_d[OP6_BNE];
  assign o_flags[F_BLT]  = op6_d[OP6_BLT];
  assign o_flags[F_BGE]  = op6_d[OP6_BGE];
  assign o_flags[F_BLTU] = op6_d[OP6_BLTU];
  assign o_flags[F_BGEU] = op6_d[OP6_BGEU];

  assign o_illegal = ~|o_flags;  // nothing matched

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f src.f --top-module tb_la_decode -o tb_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== src.f ====
+incdir+.
la_decode_pkg.sv
la_inst_match.sv
la_imm_gen.sv
la_ctrl_encode.sv
la_decode_stage.sv
tb_la_decode_assert.sv
tb_la_decode.sv

// ==== tb_la_decode_model.svh ====
`ifndef TB_LA_DECODE_MODEL_SVH
`define TB_LA_DECODE_MODEL_SVH

// one decoded item as the stage should present it
typedef struct packed {
  logic     illegal;
  logic     reg_write;
  logic     mem_write;
  logic     mem_read;
  logic     src1_pc;
  logic     src2_imm;
  alu_op_t  alu_op;
  npc_op_t  npc_op;
  dm_type_t dm_type;
  wd_sel_t  wd_sel;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm_alu;
  word_t    imm_pc;
} bundle_t;

////////////////////
// encoding table, index order follows the instruction classes

function automatic logic [31:0] inst_mask(input int k);
  if (k <= 20)      return 32'hffff8000;  // opcode down to bit 15
  else if (k <= 26) return 32'hffc00000;  // si12 / ui12 forms
  else if (k <= 28) return 32'hfe000000;  // bit 25 must be clear
  else if (k <= 36) return 32'hffc00000;  // loads and stores
  else              return 32'hfc000000;  // jumps and branches
endfunction

// {alu code, fixed opcode bits}
function automatic logic [36:0] inst_code(input int k);
  case (k)
    0:  return {ALU_ADD,    32'h00100000};  // add.w
    1:  return {ALU_SUB,    32'h00110000};  // sub.w
    2:  return {ALU_SLT,    32'h00120000};
    3:  return {ALU_SLTU,   32'h00128000};
    4:  return {ALU_NOR,    32'h00140000};
    5:  return {ALU_AND,    32'h00148000};
    6:  return {ALU_OR,     32'h00150000};
    7:  return {ALU_XOR,    32'h00158000};
    8:  return {ALU_SLL,    32'h00170000};  // sll.w
    9:  return {ALU_SRL,    32'h00178000};
    10: return {ALU_SRA,    32'h00180000};
    11: return {ALU_MULW,   32'h001c0000};
    12: return {ALU_MULHW,  32'h001c8000};
    13: return {ALU_MULHWU, 32'h001d0000};
    14: return {ALU_DIVW,   32'h00200000};
    15: return {ALU_MODW,   32'h00208000};
    16: return {ALU_DIVWU,  32'h00210000};
    17: return {ALU_MODWU,  32'h00218000};
    18: return {ALU_SLL,    32'h00408000};  // slli.w
    19: return {ALU_SRL,    32'h00448000};
    20: return {ALU_SRA,    32'h00488000};
    21: return {ALU_ADD,    32'h02800000};  // addi.w
    22: return {ALU_SLT,    32'h02000000};
    23: return {ALU_SLTU,   32'h02400000};
    24: return {ALU_AND,    32'h03400000};  // andi
    25: return {ALU_OR,     32'h03800000};
    26: return {ALU_XOR,    32'h03c00000};
    27: return {ALU_LUI,    32'h14000000};  // lu12i.w
    28: return {ALU_ADD,    32'h1c000000};  // pcaddu12i
    29: return {ALU_ADD,    32'h28000000};  // ld.b
    30: return {ALU_ADD,    32'h28400000};  // ld.h
    31: return {ALU_ADD,    32'h28800000};  // ld.w
    32: return {ALU_ADD,    32'h2a000000};  // ld.bu
    33: return {ALU_ADD,    32'h2a400000};  // ld.hu
    34: return {ALU_ADD,    32'h29000000};  // st.b
    35: return {ALU_ADD,    32'h29400000};  // st.h
    36: return {ALU_ADD,    32'h29800000};  // st.w
    37: return {ALU_ADD,    32'h4c000000};  // jirl
    38: return {ALU_ADD,    32'h50000000};  // b
    39: return {ALU_ADD,    32'h54000000};  // bl
    40: return {ALU_BEQ,    32'h58000000};
    41: return {ALU_BNE,    32'h5c000000};
    42: return {ALU_BLT,    32'h60000000};
    43: return {ALU_BGE,    32'h64000000};
    44: return {ALU_BLTU,   32'h68000000};
    45: return {ALU_BGEU,   32'h6c000000};
    default: return '0;  // no match gives ALU_NOP
  endcase
endfunction

function automatic int match_index(input inst_t w);
  logic [36:0] code;
  int          hit;
  hit = -1;
  for (int k = 0; k < NUM_INST; k++) begin
    code = inst_code(k);
    if ((w & inst_mask(k)) == code[31:0]) hit = k;
  end
  return hit;
endfunction

////////////////////
// decode rules

function automatic bundle_t predict(input inst_t w);
  bundle_t     e;
  int          k;
  logic [36:0] code;
  logic        ld;
  logic        st;
  logic        cbr;
  logic        lnk;
  logic        jmp;
  word_t       s16;
  word_t       s26;
  k    = match_index(w);
  code = inst_code(k);
  ld   = (k >= 29 && k <= 33);
  st   = (k >= 34 && k <= 36);
  cbr  = (k >= 40);
  lnk  = (k == 37 || k == 39);  // jirl, bl
  jmp  = (k == 38 || k == 39);  // b, bl
  s16  = {{14{w[25]}}, w[25:10], 2'b00};
  s26  = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
  e.illegal   = (k < 0);
  e.alu_op    = code[36:32];
  e.npc_op    = cbr ? NPC_BRANCH : jmp ? NPC_JUMP : (k == 37) ? NPC_JIRL : NPC_PLUS4;
  e.src1_pc   = lnk || k == 28;
  e.src2_imm  = lnk || (k >= 18 && k <= 36);
  e.wd_sel    = ld ? WD_MEM : lnk ? WD_PC : WD_ALU;
  e.dm_type   = (k == 30 || k == 35) ? DM_HALF :
                (k == 33)            ? DM_HALF_U :
                (k == 29 || k == 34) ? DM_BYTE :
                (k == 32)            ? DM_BYTE_U : DM_WORD;
  e.mem_read  = ld;
  e.mem_write = st;
  e.reg_write = k >= 0 && !st && !cbr && k != 38;
  e.rd        = (k == 39) ? LINK_REG : w[4:0];
  e.rs1       = w[9:5];
  e.rs2       = (st || cbr) ? w[4:0] : w[14:10];
  if (lnk)                     e.imm_alu = IMM_PLUS4;
  else if (k == 27 || k == 28) e.imm_alu = {w[24:5], 12'b0};
  else if (cbr)                e.imm_alu = s16;
  else if (jmp)                e.imm_alu = s26;
  else if (k >= 18 && k <= 20) e.imm_alu = {27'b0, w[14:10]};
  else if (k >= 24 && k <= 26) e.imm_alu = {20'b0, w[21:10]};
  else                         e.imm_alu = {{20{w[21]}}, w[21:10]};
  e.imm_pc = jmp ? s26 : (cbr || k == 37) ? s16 : 32'd0;
  return e;
endfunction

`endif

// ==== tb_la_decode.sv ====
`timescale 1ns/10ps

module tb_la_decode import la_decode_pkg::*; ();

  logic     clk;
  logic     i_rst_n;
  logic     i_valid;
  inst_t    i_inst;
  logic     o_valid;
  logic     o_reg_write;
  logic     o_mem_write;
  logic     o_mem_read;
  logic     o_alu_src1_pc;
  logic     o_alu_src2_imm;
  alu_op_t  o_alu_op;
  npc_op_t  o_npc_op;
  dm_type_t o_dm_type;
  wd_sel_t  o_wd_sel;
  reg_idx_t o_rd;
  reg_idx_t o_rs1;
  reg_idx_t o_rs2;
  word_t    o_imm_alu;
  word_t    o_imm_pc;
  logic     o_illegal;

  `include "tb_la_decode_model.svh"

  logic [15:0] lfsr = 16'd63;
  int          errs [1:6];
  int          items [1:6];
  int          n_in;     // accepted items
  int          n_out;    // valid output cycles
  int          n_legal;
  bundle_t     exp_b;
  logic        exp_valid;

  la_decode_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // stimulus source

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // checking

  task automatic check(input int t, input string name, input logic [31:0] exp,
                       input logic [31:0] act);
    assert (exp === act) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      errs[t]++;
    end
  endtask

  task automatic check_idle(input int t);
    check(t, "o_valid", 32'd0, 32'(o_valid));
    check(t, "o_reg_write", 32'd0, 32'(o_reg_write));
    check(t, "o_mem_write", 32'd0, 32'(o_mem_write));
    check(t, "o_mem_read", 32'd0, 32'(o_mem_read));
  endtask

  // compare what the last edge registered with what was driven before it
  task automatic sample_outputs();
    int t_ctl;
    int t_imm;
    int t_reg;
    if (o_valid === 1'b1) n_out++;
    if (!exp_valid) begin
      items[6]++;
      check_idle(6);
    end else begin
      t_ctl = exp_b.illegal ? 5 : 2;  // illegal words all count as test 5
      t_imm = exp_b.illegal ? 5 : 3;
      t_reg = exp_b.illegal ? 5 : 4;
      items[t_ctl]++;
      if (!exp_b.illegal) begin
        items[3]++;
        items[4]++;
      end
      check(6, "o_valid", 32'd1, 32'(o_valid));
      check(t_ctl, "o_illegal", 32'(exp_b.illegal), 32'(o_illegal));
      check(t_ctl, "o_reg_write", 32'(exp_b.reg_write), 32'(o_reg_write));
      check(t_ctl, "o_mem_write", 32'(exp_b.mem_write), 32'(o_mem_write));
      check(t_ctl, "o_mem_read", 32'(exp_b.mem_read), 32'(o_mem_read));
      check(t_ctl, "o_alu_src1_pc", 32'(exp_b.src1_pc), 32'(o_alu_src1_pc));
      check(t_ctl, "o_alu_src2_imm", 32'(exp_b.src2_imm), 32'(o_alu_src2_imm));
      check(t_ctl, "o_alu_op", 32'(exp_b.alu_op), 32'(o_alu_op));
      check(t_ctl, "o_npc_op", 32'(exp_b.npc_op), 32'(o_npc_op));
      check(t_ctl, "o_dm_type", 32'(exp_b.dm_type), 32'(o_dm_type));
      check(t_ctl, "o_wd_sel", 32'(exp_b.wd_sel), 32'(o_wd_sel));
      check(t_imm, "o_imm_alu", exp_b.imm_alu, o_imm_alu);
      check(t_imm, "o_imm_pc", exp_b.imm_pc, o_imm_pc);
      check(t_reg, "o_rd", 32'(exp_b.rd), 32'(o_rd));
      check(t_reg, "o_rs1", 32'(exp_b.rs1), 32'(o_rs1));
      check(t_reg, "o_rs2", 32'(exp_b.rs2), 32'(o_rs2));
    end
  endtask

  ////////////////////
  // main sequence

  initial begin
    int          cnt;
    int          k;
    int          total;
    logic [31:0] v;
    logic [31:0] r;
    logic [36:0] code;
    i_rst_n   = 1'b0;
    i_valid   = 1'b0;
    i_inst    = '0;
    exp_valid = 1'b0;
    n_in      = 0;
    n_out     = 0;
    n_legal   = 0;
    for (int t = 1; t <= 6; t++) begin
      errs[t]  = 0;
      items[t] = 0;
    end

    repeat (5) @(posedge clk);
    #1;
    check_idle(1);  // still in reset
    i_rst_n = 1'b1;
    cnt = 0;
    while (o_valid !== 1'b0 && cnt < 20) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (o_valid !== 1'b0) begin
      $display("Timeout: output valid stayed high after reset");
      errs[1]++;
    end
    @(posedge clk);
    #1;
    check_idle(1);
    $display("test 1 reset state: %0d errors", errs[1]);

    for (int step = 0; step < 4000 && n_legal < 400; step++) begin
      @(posedge clk);
      #1;
      sample_outputs();
      draw(1, v);
      i_valid = v[0];
      draw(3, v);
      if (v[2:0] < 3'd6) begin
        draw(6, v);
        k = int'(v % 32'd46);
        code = inst_code(k);
        draw(32, r);
        i_inst = (r & ~inst_mask(k)) | code[31:0];  // random operand fields
      end else begin
        draw(32, r);
        i_inst = r;
      end
      exp_valid = i_valid;
      exp_b     = predict(i_inst);
      if (i_valid) begin
        n_in++;
        if (!exp_b.illegal) n_legal++;
      end
    end

    // drain the last item, then wait for the bubble
    cnt = 0;
    do begin
      @(posedge clk);
      #1;
      sample_outputs();
      i_valid   = 1'b0;
      exp_valid = 1'b0;
      cnt++;
    end while (o_valid !== 1'b0 && cnt < 10);
    if (o_valid !== 1'b0) begin
      $display("Timeout: output valid did not drop after the last item");
      errs[6]++;
    end

    if (n_legal < 400) begin
      $display("Only %0d legal items were sent, 400 needed", n_legal);
      errs[2]++;
    end
    if (items[5] == 0) begin
      $display("No illegal word came up in the random stream");
      errs[5]++;
    end
    assert (n_in == n_out) else begin
      $display("Accepted %0d items but %0d valid output cycles came out", n_in, n_out);
      errs[6]++;
    end

    $display("test 2 control codes: %0d items, %0d errors", items[2], errs[2]);
    $display("test 3 immediates: %0d items, %0d errors", items[3], errs[3]);
    $display("test 4 register indices: %0d items, %0d errors", items[4], errs[4]);
    $display("test 5 illegal words: %0d items, %0d errors", items[5], errs[5]);
    $display("test 6 bubbles and ordering: %0d bubbles, %0d errors", items[6], errs[6]);

    total = dut.u_assert.fails;
    for (int t = 1; t <= 6; t++) total += errs[t];
    $display("summary: %0d checks failed, %0d assertion failures, %0d items accepted",
             total - dut.u_assert.fails, dut.u_assert.fails, n_in);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tb_la_decode_assert.sv ====
`timescale 1ns/10ps

module la_decode_assert import la_decode_pkg::*; (
  input logic        i_clk,
  input logic        i_rst_n,
  input logic        i_valid,
  input logic        i_reg_write,
  input logic        i_mem_write,
  input logic        i_mem_read,
  input logic        i_illegal,
  input inst_flags_t i_flags
);

  int   fails = 0;  // failed assertion count
  logic any_en;

  assign any_en = i_reg_write | i_mem_write | i_mem_read;

  // enables only ride with a valid item
  a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_valid |-> !any_en)
    else begin
      $error("enable high while output valid is low");
      fails++;
    end

  a_mem_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_mem_read && i_mem_write))
    else begin
      $error("memory read and write both high");
      fails++;
    end

  a_flags_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(i_flags))  // encodings never overlap
    else begin
      $error("more than one instruction flag set");
      fails++;
    end

  a_illegal_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid && i_illegal |-> !any_en)
    else begin
      $error("illegal instruction with an enable set");
      fails++;
    end

endmodule

bind la_decode_stage la_decode_assert u_assert (
  .i_clk       (clk),
  .i_rst_n     (i_rst_n),
  .i_valid     (o_valid),
  .i_reg_write (o_reg_write),
  .i_mem_write (o_mem_write),
  .i_mem_read  (o_mem_read),
  .i_illegal   (o_illegal),
  .i_flags     (flags)
);
